// ==== issue_top.f ====
+incdir+src
src/issue_pkg.sv
src/issue_regfile.sv
src/issue_queue.sv
src/issue_exe.sv
src/issue_top.sv
tests/issue_top_tb.sv

// ==== src/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

//////////////////////////////////////////////////
// Issue stage sizing
//////////////////////////////////////////////////

// Queue entries, power of two
`define ISSUE_DEPTH 8

// Data and PC width
`define XLEN 32

// Architectural registers
`define NREG 32

`endif

// ==== src/issue_exe.sv ====
`default_nettype none

module issue_exe
    import issue_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_flush,
    input  wire logic        i_stall,
    input  wire issue_inst_t i_inst0,
    input  wire issue_inst_t i_inst1,
    input  wire logic        i_issue0,
    input  wire logic        i_issue1,
    input  wire xword_t      i_rdata0,
    input  wire xword_t      i_rdata1,
    input  wire xword_t      i_rdata2,
    input  wire xword_t      i_rdata3,
    output logic             o_ex_a_valid,
    output logic             o_ex_b_valid,
    output xword_t           o_pc_a,
    output xword_t           o_pc_b,
    output xword_t           o_src1_a,
    output xword_t           o_src1_b,
    output xword_t           o_src2_a,
    output xword_t           o_src2_b,
    output xword_t           o_imm_a,
    output xword_t           o_imm_b,
    output logic [3:0]       o_alu_op_a,
    output logic [3:0]       o_alu_op_b,
    output reg_addr_t        o_rd_a,
    output reg_addr_t        o_rd_b,
    output logic             o_rf_we_a,
    output logic             o_rf_we_b,
    output logic             o_mem_we_a,
    output logic             o_mem_we_b,
    output logic             o_br_pd_a,
    output logic             o_br_pd_b,
    output logic             o_mul_en,
    output logic             o_div_en
);

    logic        swap;
    issue_inst_t lane_a_inst;
    issue_inst_t lane_b_inst;
    logic        lane_a_vld;
    logic        lane_b_vld;
    xword_t      lane_a_src1;
    xword_t      lane_a_src2;
    xword_t      lane_b_src1;
    xword_t      lane_b_src2;
    logic        lane_a_pd;
    logic        lane_b_pd;
    inst_class_t cls_a_q;

    //////////////////////////////////////////////////
    // Lane steering
    //////////////////////////////////////////////////

    assign swap = (i_inst0.cls != CLS_ALU);     // Older goes to lane b

    always_comb begin
        if (swap) begin
            lane_a_inst = i_inst1;
            lane_a_vld  = i_issue1;
            lane_a_src1 = i_rdata2;
            lane_a_src2 = i_rdata3;
            lane_b_inst = i_inst0;
            lane_b_vld  = i_issue0;
            lane_b_src1 = i_rdata0;
            lane_b_src2 = i_rdata1;
        end else begin
            lane_a_inst = i_inst0;
            lane_a_vld  = i_issue0;
            lane_a_src1 = i_rdata0;
            lane_a_src2 = i_rdata1;
            lane_b_inst = i_inst1;
            lane_b_vld  = i_issue1;
            lane_b_src1 = i_rdata2;
            lane_b_src2 = i_rdata3;
        end
    end

    //////////////////////////////////////////////////

    // Predicted taken when next PC is not sequential
    assign lane_a_pd = (lane_a_inst.pc_pre != lane_a_inst.pc + xword_t'(4));
    assign lane_b_pd = (lane_b_inst.pc_pre != lane_b_inst.pc + xword_t'(4));

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            o_ex_a_valid <= 1'b0;
            o_ex_b_valid <= 1'b0;
            o_rf_we_a    <= 1'b0;
            o_rf_we_b    <= 1'b0;
            o_mem_we_a   <= 1'b0;
            o_mem_we_b   <= 1'b0;
            o_br_pd_a    <= 1'b0;
            o_br_pd_b    <= 1'b0;
            o_mul_en     <= 1'b0;
            o_div_en     <= 1'b0;
        end else if (!i_stall) begin
            o_ex_a_valid <= lane_a_vld;
            o_ex_b_valid <= lane_b_vld;
            o_rf_we_a    <= lane_a_vld && lane_a_inst.rf_we;
            o_rf_we_b    <= lane_b_vld && lane_b_inst.rf_we;
            o_mem_we_a   <= lane_a_vld && lane_a_inst.mem_we;
            o_mem_we_b   <= lane_b_vld && lane_b_inst.mem_we;
            o_br_pd_a    <= lane_a_vld && lane_a_pd;
            o_br_pd_b    <= lane_b_vld && lane_b_pd;
            o_mul_en     <= lane_b_vld && (lane_b_inst.cls == CLS_MUL);
            o_div_en     <= lane_b_vld && (lane_b_inst.cls == CLS_DIV);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_pc_a     <= lane_a_inst.pc;
            o_pc_b     <= lane_b_inst.pc;
            o_src1_a   <= lane_a_src1;
            o_src2_a   <= lane_a_src2;
            o_src1_b   <= lane_b_src1;
            o_src2_b   <= lane_b_src2;
            o_imm_a    <= lane_a_inst.imm;
            o_imm_b    <= lane_b_inst.imm;
            o_alu_op_a <= lane_a_inst.alu_op;
            o_alu_op_b <= lane_b_inst.alu_op;
            o_rd_a     <= lane_a_inst.rd;
            o_rd_b     <= lane_b_inst.rd;
            cls_a_q    <= lane_a_inst.cls;
        end
    end

    // Relies on the queue never pairing two non-ALU instructions
    a_lane_a_alu: assert property (@(posedge clk) disable iff (!rstn)
        o_ex_a_valid |-> (cls_a_q == CLS_ALU))
        else $error("non-ALU instruction on lane a");

endmodule

`default_nettype wire

// ==== src/issue_pkg.sv ====
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    localparam int REG_AW = $clog2(`NREG);     // Register address width

    typedef logic [`XLEN-1:0]  xword_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // Instruction class
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CLS_ALU = 3'd0,                         // Plain ALU, either lane
        CLS_MUL = 3'd1,                         // Lane b only
        CLS_DIV = 3'd2,                         // Lane b only
        CLS_BR  = 3'd3,                         // Lane b only
        CLS_CSR = 3'd4                          // Lane b only
    } inst_class_t;

    //////////////////////////////////////////////////
    // Decoded instruction
    //////////////////////////////////////////////////

    typedef struct packed {
        xword_t      pc;
        xword_t      pc_pre;                    // Predicted next PC
        inst_class_t cls;
        reg_addr_t   raddr1;
        reg_addr_t   raddr2;
        reg_addr_t   rd;
        logic        rf_we;
        xword_t      imm;
        logic [3:0]  alu_op;
        logic        mem_we;
    } issue_inst_t;

endpackage

`default_nettype wire

// ==== src/issue_queue.sv ====
`default_nettype none

`include "issue_cfg.svh"

module issue_queue
    import issue_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_flush,
    input  wire logic        i_stall,
    input  wire logic        i_push_a,
    input  wire logic        i_push_b,
    input  wire issue_inst_t i_inst_a,
    input  wire issue_inst_t i_inst_b,
    output logic             o_full,
    output issue_inst_t      o_inst0,
    output issue_inst_t      o_inst1,
    output logic             o_issue0,
    output logic             o_issue1
);

    localparam int AW = $clog2(`ISSUE_DEPTH);
    localparam int CW = AW + 1;

    issue_inst_t   mem [`ISSUE_DEPTH];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          valid0;
    logic          valid1;
    logic          raw_hit;
    logic          both_ext;
    logic [1:0]    n_push;
    logic [1:0]    n_pop;

    //////////////////////////////////////////////////
    // Head pair and pair rule
    //////////////////////////////////////////////////

    assign o_inst0 = mem[rd_ptr];
    assign o_inst1 = mem[rd_ptr + AW'(1)];

    assign valid0 = (count != '0);
    assign valid1 = (count > CW'(1));

    // Younger reads what the head writes
    assign raw_hit = o_inst0.rf_we &&
                     ((o_inst1.raddr1 == o_inst0.rd) || (o_inst1.raddr2 == o_inst0.rd));

    // Only one lane takes non-ALU work
    assign both_ext = (o_inst0.cls != CLS_ALU) && (o_inst1.cls != CLS_ALU);

    assign o_issue0 = valid0 && !i_stall && !i_flush;
    assign o_issue1 = o_issue0 && valid1 && !raw_hit && !both_ext;

    assign n_push = {1'b0, i_push_a} + {1'b0, i_push_b};
    assign n_pop  = {1'b0, o_issue0} + {1'b0, o_issue1};

    assign o_full = (count > CW'(`ISSUE_DEPTH - 2));    // Room for a pair

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_push_a) begin
            mem[wr_ptr] <= i_inst_a;                    // Older first
            if (i_push_b) begin
                mem[wr_ptr + AW'(1)] <= i_inst_b;
            end
        end else if (i_push_b) begin
            mem[wr_ptr] <= i_inst_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;                               // Drops same-cycle pushes too
        end else begin
            rd_ptr <= rd_ptr + AW'(n_pop);
            wr_ptr <= wr_ptr + AW'(n_push);
            count  <= count + CW'(n_push) - CW'(n_pop);
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_push_full: assert property (@(posedge clk) disable iff (!rstn)
        (i_push_a || i_push_b) |-> !o_full)
        else $error("push while queue full");

    // Count never runs past the depth
    a_count_range: assert property (@(posedge clk) disable iff (!rstn)
        count <= CW'(`ISSUE_DEPTH))
        else $error("queue count overflow");

endmodule

`default_nettype wire

// ==== src/issue_regfile.sv ====
`default_nettype none

`include "issue_cfg.svh"

module issue_regfile
    import issue_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic [REG_AW-1:0] i_raddr0,
    input  wire logic [REG_AW-1:0] i_raddr1,
    input  wire logic [REG_AW-1:0] i_raddr2,
    input  wire logic [REG_AW-1:0] i_raddr3,
    output xword_t      o_rdata0,
    output xword_t      o_rdata1,
    output xword_t      o_rdata2,
    output xword_t      o_rdata3,
    input  wire logic   i_we_a,
    input  wire logic [REG_AW-1:0] i_waddr_a,
    input  wire logic [`XLEN-1:0]  i_wdata_a,
    input  wire logic   i_we_b,
    input  wire logic [REG_AW-1:0] i_waddr_b,
    input  wire logic [`XLEN-1:0]  i_wdata_b
);

    xword_t regs [`NREG];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_we_a && (i_waddr_a != '0)) begin
                regs[i_waddr_a] <= i_wdata_a;
            end
            if (i_we_b && (i_waddr_b != '0)) begin   // Port b wins on a shared address
                regs[i_waddr_b] <= i_wdata_b;
            end
        end
    end

    // Writes show up on the next cycle
    assign o_rdata0 = (i_raddr0 == '0) ? '0 : regs[i_raddr0];
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];
    assign o_rdata3 = (i_raddr3 == '0) ? '0 : regs[i_raddr3];

    a_waddr_range: assert property (@(posedge clk) disable iff (!rstn)
        (i_we_a |-> !$isunknown(i_waddr_a)) and (i_we_b |-> !$isunknown(i_waddr_b)))
        else $error("regfile write to an unknown address");

endmodule

`default_nettype wire

// ==== src/issue_top.sv ====
`default_nettype none

module issue_top
    import issue_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_push_a,
    input  wire logic        i_push_b,
    input  wire issue_inst_t i_inst_a,
    input  wire issue_inst_t i_inst_b,
    input  wire logic        i_wb_we_a,
    input  wire reg_addr_t   i_wb_addr_a,
    input  wire xword_t      i_wb_data_a,
    input  wire logic        i_wb_we_b,
    input  wire reg_addr_t   i_wb_addr_b,
    input  wire xword_t      i_wb_data_b,
    input  wire logic        i_stall,
    input  wire logic        i_flush,
    output logic             o_full,
    output logic             o_ex_a_valid,
    output logic             o_ex_b_valid,
    output xword_t           o_pc_a,
    output xword_t           o_pc_b,
    output xword_t           o_src1_a,
    output xword_t           o_src1_b,
    output xword_t           o_src2_a,
    output xword_t           o_src2_b,
    output xword_t           o_imm_a,
    output xword_t           o_imm_b,
    output logic [3:0]       o_alu_op_a,
    output logic [3:0]       o_alu_op_b,
    output reg_addr_t        o_rd_a,
    output reg_addr_t        o_rd_b,
    output logic             o_rf_we_a,
    output logic             o_rf_we_b,
    output logic             o_mem_we_a,
    output logic             o_mem_we_b,
    output logic             o_br_pd_a,
    output logic             o_br_pd_b,
    output logic             o_mul_en,
    output logic             o_div_en
);

    issue_inst_t q_inst0;                       // Queue head
    issue_inst_t q_inst1;                       // Head plus one
    logic        q_issue0;
    logic        q_issue1;
    xword_t      rf_rdata0;
    xword_t      rf_rdata1;
    xword_t      rf_rdata2;
    xword_t      rf_rdata3;

    issue_queue issue_queue_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_flush  (i_flush),
        .i_stall  (i_stall),
        .i_push_a (i_push_a),
        .i_push_b (i_push_b),
        .i_inst_a (i_inst_a),
        .i_inst_b (i_inst_b),
        .o_full   (o_full),
        .o_inst0  (q_inst0),
        .o_inst1  (q_inst1),
        .o_issue0 (q_issue0),
        .o_issue1 (q_issue1)
    );

    issue_regfile issue_regfile_i (
        .clk       (clk),
        .rstn      (rstn),
        .i_raddr0  (q_inst0.raddr1),
        .i_raddr1  (q_inst0.raddr2),
        .i_raddr2  (q_inst1.raddr1),
        .i_raddr3  (q_inst1.raddr2),
        .o_rdata0  (rf_rdata0),
        .o_rdata1  (rf_rdata1),
        .o_rdata2  (rf_rdata2),
        .o_rdata3  (rf_rdata3),
        .i_we_a    (i_wb_we_a),
        .i_waddr_a (i_wb_addr_a),
        .i_wdata_a (i_wb_data_a),
        .i_we_b    (i_wb_we_b),
        .i_waddr_b (i_wb_addr_b),
        .i_wdata_b (i_wb_data_b)
    );

    issue_exe issue_exe_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_stall      (i_stall),
        .i_inst0      (q_inst0),
        .i_inst1      (q_inst1),
        .i_issue0     (q_issue0),
        .i_issue1     (q_issue1),
        .i_rdata0     (rf_rdata0),
        .i_rdata1     (rf_rdata1),
        .i_rdata2     (rf_rdata2),
        .i_rdata3     (rf_rdata3),
        .o_ex_a_valid (o_ex_a_valid),
        .o_ex_b_valid (o_ex_b_valid),
        .o_pc_a       (o_pc_a),
        .o_pc_b       (o_pc_b),
        .o_src1_a     (o_src1_a),
        .o_src1_b     (o_src1_b),
        .o_src2_a     (o_src2_a),
        .o_src2_b     (o_src2_b),
        .o_imm_a      (o_imm_a),
        .o_imm_b      (o_imm_b),
        .o_alu_op_a   (o_alu_op_a),
        .o_alu_op_b   (o_alu_op_b),
        .o_rd_a       (o_rd_a),
        .o_rd_b       (o_rd_b),
        .o_rf_we_a    (o_rf_we_a),
        .o_rf_we_b    (o_rf_we_b),
        .o_mem_we_a   (o_mem_we_a),
        .o_mem_we_b   (o_mem_we_b),
        .o_br_pd_a    (o_br_pd_a),
        .o_br_pd_b    (o_br_pd_b),
        .o_mul_en     (o_mul_en),
        .o_div_en     (o_div_en)
    );

endmodule

`default_nettype wire

// ==== tests/issue_top_tb.sv ====
`default_nettype none

module issue_top_tb
    import issue_pkg::*;
;

    localparam int CLK_PERIOD      = 40;
    localparam int N_RAND_PAIRS    = 20;
    localparam int N_DIRECT        = 28;
    localparam int N_INSTS         = N_DIRECT + 2 * N_RAND_PAIRS;
    localparam int WATCHDOG_CYCLES = N_INSTS * 20 + 200;
    localparam int DRAIN_LIMIT     = 100;
    localparam int NREG_MODEL      = 1 << REG_AW;

    typedef struct packed {
        logic        vld_a;
        logic        vld_b;
        issue_inst_t ins_a;
        issue_inst_t ins_b;
        xword_t      s1a;
        xword_t      s2a;
        xword_t      s1b;
        xword_t      s2b;
    } lanes_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        i_push_a, i_push_b, i_wb_we_a, i_wb_we_b, i_stall, i_flush;
    issue_inst_t i_inst_a, i_inst_b;
    reg_addr_t   i_wb_addr_a, i_wb_addr_b;
    xword_t      i_wb_data_a, i_wb_data_b;
    logic        o_full, o_ex_a_valid, o_ex_b_valid;
    xword_t      o_pc_a, o_pc_b, o_src1_a, o_src1_b, o_src2_a, o_src2_b, o_imm_a, o_imm_b;
    logic [3:0]  o_alu_op_a, o_alu_op_b;
    reg_addr_t   o_rd_a, o_rd_b;
    logic        o_rf_we_a, o_rf_we_b, o_mem_we_a, o_mem_we_b;
    logic        o_br_pd_a, o_br_pd_b, o_mul_en, o_div_en;

    int          seed = 88256;
    int          mism_cnt = 0;
    int          other_cnt = 0;
    int          n_pushed = 0;
    int          n_dropped = 0;
    int          n_delivered = 0;
    issue_inst_t mq [$];                            // Model queue
    xword_t      mregs [NREG_MODEL];
    lanes_t      exp_now;
    logic        held = 1'b0;

    issue_top issue_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic xword_t reg_value(input reg_addr_t a);
        return (a == '0) ? '0 : mregs[a];
    endfunction

    function automatic lanes_t predict_lanes(input int avail, input issue_inst_t i0,
                                             input issue_inst_t i1);
        lanes_t l;
        logic   go0;
        logic   go1;
        logic   dep;
        go0 = (avail >= 1);
        dep = i0.rf_we && ((i1.raddr1 == i0.rd) || (i1.raddr2 == i0.rd));
        go1 = go0 && (avail >= 2) && !dep && !((i0.cls != CLS_ALU) && (i1.cls != CLS_ALU));
        if (i0.cls != CLS_ALU) begin                // Older non-ALU takes lane b
            l.ins_a = i1;
            l.vld_a = go1;
            l.ins_b = i0;
            l.vld_b = go0;
        end else begin
            l.ins_a = i0;
            l.vld_a = go0;
            l.ins_b = i1;
            l.vld_b = go1;
        end
        l.s1a = reg_value(l.ins_a.raddr1);
        l.s2a = reg_value(l.ins_a.raddr2);
        l.s1b = reg_value(l.ins_b.raddr1);
        l.s2b = reg_value(l.ins_b.raddr2);
        return l;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            mq.delete();
            exp_now = '0;
            held    = 1'b0;
            for (int i = 0; i < NREG_MODEL; i++) begin
                mregs[i] = '0;
            end
        end else begin
            held = i_stall && !i_flush;
            n_pushed += int'(i_push_a) + int'(i_push_b);
            if (i_flush) begin
                n_dropped += mq.size() + int'(i_push_a) + int'(i_push_b);
                mq.delete();
                exp_now = '0;
            end else begin
                if (!i_stall) begin
                    exp_now = predict_lanes(mq.size(), (mq.size() > 0) ? mq[0] : '0,
                                            (mq.size() > 1) ? mq[1] : '0);
                    repeat (int'(exp_now.vld_a) + int'(exp_now.vld_b)) void'(mq.pop_front());
                end
                if (i_push_a) mq.push_back(i_inst_a);
                if (i_push_b) mq.push_back(i_inst_b);
            end
            if (i_wb_we_a && i_wb_addr_a != '0) mregs[i_wb_addr_a] = i_wb_data_a;
            if (i_wb_we_b && i_wb_addr_b != '0) mregs[i_wb_addr_b] = i_wb_data_b;  // b wins
        end
    end

    //////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////

    task automatic check_val(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            mism_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, field, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            check_val("o_ex_a_valid", o_ex_a_valid, exp_now.vld_a);
            check_val("o_ex_b_valid", o_ex_b_valid, exp_now.vld_b);
            check_val("o_full", o_full, mq.size() > 6);
            check_val("o_rf_we_a", o_rf_we_a, exp_now.vld_a && exp_now.ins_a.rf_we);
            check_val("o_rf_we_b", o_rf_we_b, exp_now.vld_b && exp_now.ins_b.rf_we);
            check_val("o_mem_we_a", o_mem_we_a, exp_now.vld_a && exp_now.ins_a.mem_we);
            check_val("o_mem_we_b", o_mem_we_b, exp_now.vld_b && exp_now.ins_b.mem_we);
            check_val("o_br_pd_a", o_br_pd_a,
                      exp_now.vld_a && (exp_now.ins_a.pc_pre != exp_now.ins_a.pc + 32'd4));
            check_val("o_br_pd_b", o_br_pd_b,
                      exp_now.vld_b && (exp_now.ins_b.pc_pre != exp_now.ins_b.pc + 32'd4));
            check_val("o_mul_en", o_mul_en, exp_now.vld_b && exp_now.ins_b.cls == CLS_MUL);
            check_val("o_div_en", o_div_en, exp_now.vld_b && exp_now.ins_b.cls == CLS_DIV);
            if (exp_now.vld_a) begin
                check_val("o_pc_a", o_pc_a, exp_now.ins_a.pc);
                check_val("o_src1_a", o_src1_a, exp_now.s1a);
                check_val("o_src2_a", o_src2_a, exp_now.s2a);
                check_val("o_imm_a", o_imm_a, exp_now.ins_a.imm);
                check_val("o_alu_op_a", o_alu_op_a, exp_now.ins_a.alu_op);
                check_val("o_rd_a", o_rd_a, exp_now.ins_a.rd);
            end
            if (exp_now.vld_b) begin
                check_val("o_pc_b", o_pc_b, exp_now.ins_b.pc);
                check_val("o_src1_b", o_src1_b, exp_now.s1b);
                check_val("o_src2_b", o_src2_b, exp_now.s2b);
                check_val("o_imm_b", o_imm_b, exp_now.ins_b.imm);
                check_val("o_alu_op_b", o_alu_op_b, exp_now.ins_b.alu_op);
                check_val("o_rd_b", o_rd_b, exp_now.ins_b.rd);
            end
            if (!held) begin                        // Held outputs are not new results
                n_delivered += int'(o_ex_a_valid) + int'(o_ex_b_valid);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    function automatic issue_inst_t make_inst(input inst_class_t cls, input reg_addr_t r1,
                                              input reg_addr_t r2, input reg_addr_t rd,
                                              input logic we);
        issue_inst_t ins;
        ins.pc     = xword_t'($random(seed)) & 32'hffff_fffc;
        ins.pc_pre = ins.pc + 32'd4;
        ins.cls    = cls;
        ins.raddr1 = r1;
        ins.raddr2 = r2;
        ins.rd     = rd;
        ins.rf_we  = we;
        ins.imm    = $random(seed);
        ins.alu_op = 4'($random(seed));
        ins.mem_we = 1'($random(seed));
        return ins;
    endfunction

    task automatic push_pair(input issue_inst_t a, input logic va, input issue_inst_t b,
                             input logic vb);
        while (o_full) begin
            i_stall = 1'b0;                         // Let the queue drain
            next_cycle();
        end
        i_inst_a = a;
        i_push_a = va;
        i_inst_b = b;
        i_push_b = vb;
        next_cycle();
        i_push_a = 1'b0;
        i_push_b = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t aa, input xword_t da, input logic wa,
                            input reg_addr_t ab, input xword_t db, input logic wb);
        i_wb_addr_a = aa;
        i_wb_data_a = da;
        i_wb_we_a   = wa;
        i_wb_addr_b = ab;
        i_wb_data_b = db;
        i_wb_we_b   = wb;
        next_cycle();
        i_wb_we_a = 1'b0;
        i_wb_we_b = 1'b0;
    endtask

    task automatic wait_drain;
        int waited;
        waited  = 0;
        i_stall = 1'b0;
        while ((mq.size() != 0 || n_delivered != n_pushed - n_dropped) &&
               waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (mq.size() != 0 || n_delivered != n_pushed - n_dropped) begin
            other_cnt++;
            $display("results missing at %0t: %0d instructions kept, %0d delivered", $time,
                     n_pushed - n_dropped, n_delivered);
        end
    endtask

    initial begin
        issue_inst_t x;
        issue_inst_t y;
        inst_class_t ext [4];
        ext = '{CLS_MUL, CLS_DIV, CLS_BR, CLS_CSR};
        rstn = 1'b0;
        {i_push_a, i_push_b, i_wb_we_a, i_wb_we_b, i_stall, i_flush} = '0;
        {i_inst_a, i_inst_b} = '0;
        {i_wb_addr_a, i_wb_addr_b, i_wb_data_a, i_wb_data_b} = '0;
        repeat (4) @(posedge clk);
        #2 rstn = 1'b1;
        for (int r = 1; r < 32; r += 2) begin       // Last pair also hits r0
            wb_write(reg_addr_t'(r), $random(seed), 1'b1,
                     reg_addr_t'(r + 1), $random(seed), 1'b1);
        end
        push_pair(make_inst(CLS_ALU, 3, 4, 10, 1), 1'b1, '0, 1'b0);
        wait_drain();
        foreach (ext[k]) begin                      // Older non-ALU gets swapped
            push_pair(make_inst(ext[k], 1, 2, 11, 1), 1'b1,
                      make_inst(CLS_ALU, 5, 6, 12, 1), 1'b1);
        end
        wait_drain();
        push_pair(make_inst(CLS_ALU, 1, 2, 5, 1), 1'b1, make_inst(CLS_ALU, 5, 3, 6, 1), 1'b1);
        push_pair(make_inst(CLS_MUL, 1, 2, 7, 1), 1'b1, make_inst(CLS_DIV, 3, 4, 8, 1), 1'b1);
        wait_drain();
        for (int k = 0; k < 3; k++) begin
            push_pair(make_inst(CLS_ALU, k, k + 1, 20, 1), 1'b1,
                      make_inst(CLS_MUL, k + 2, k + 3, 21, 1), 1'b1);
        end
        i_stall = 1'b1;
        repeat (4) next_cycle();
        wait_drain();
        i_stall = 1'b1;                             // Fill under stall before the flush
        push_pair(make_inst(CLS_ALU, 1, 2, 3, 1), 1'b1, make_inst(CLS_ALU, 4, 5, 6, 1), 1'b1);
        push_pair(make_inst(CLS_DIV, 1, 2, 3, 1), 1'b1, make_inst(CLS_ALU, 4, 5, 6, 1), 1'b1);
        i_flush  = 1'b1;
        i_inst_a = make_inst(CLS_ALU, 7, 8, 9, 1);
        i_push_a = 1'b1;
        next_cycle();
        {i_flush, i_push_a, i_stall} = '0;
        push_pair(make_inst(CLS_ALU, 9, 10, 11, 1), 1'b1, '0, 1'b0);
        wait_drain();
        x = make_inst(CLS_BR, 1, 2, 0, 0);
        x.pc_pre = x.pc + 32'd64;                   // Predicted taken
        push_pair(x, 1'b1, make_inst(CLS_ALU, 3, 4, 13, 1), 1'b1);
        wb_write(7, 32'h1111_1111, 1'b1, 7, 32'h2222_2222, 1'b1);
        push_pair(make_inst(CLS_ALU, 7, 0, 14, 1), 1'b1, '0, 1'b0);
        wait_drain();
        for (int k = 0; k < N_RAND_PAIRS; k++) begin
            x = make_inst(inst_class_t'($unsigned($random(seed)) % 5),
                          reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                          reg_addr_t'($random(seed)), 1'($random(seed)));
            y = make_inst(inst_class_t'($unsigned($random(seed)) % 5),
                          reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                          reg_addr_t'($random(seed)), 1'($random(seed)));
            i_stall     = ($unsigned($random(seed)) % 4 == 0);
            i_wb_we_a   = 1'($random(seed));
            i_wb_addr_a = reg_addr_t'($random(seed));
            i_wb_data_a = $random(seed);
            push_pair(x, 1'b1, y, 1'b1);
            i_wb_we_a = 1'b0;
        end
        wait_drain();
        repeat (2) next_cycle();
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
